/* rtl/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

  typedef logic [31:0] pc_t;
  typedef logic [15:0] parcel_t;
  typedef logic [63:0] fetch_word_t;  // parcel 0 sits in bits 15:0
  typedef logic [31:0] instr_t;

  // one stored parcel together with the pc it was fetched from
  typedef struct packed {
    pc_t     pc;
    parcel_t parcel;
  } parcel_entry_t;

  // p0 is kept in the low bits so the row can be viewed as parcel_entry_t [3:0]
  typedef struct packed {
    parcel_entry_t p3;
    parcel_entry_t p2;
    parcel_entry_t p1;
    parcel_entry_t p0;
  } parcel_row_t;

  typedef struct packed {
    logic        ready;
    logic        clear;
    logic        align;  // drop the first parcel of the next fetch
    logic        stall;
    pc_t         pc;
    fetch_word_t rdata;
  } fetch_in_t;

  typedef struct packed {
    pc_t    pc0;
    pc_t    pc1;
    instr_t instr0;
    instr_t instr1;
    logic   ready0;
    logic   ready1;
    logic   full;
  } issue_out_t;

endpackage

`default_nettype wire

/* rtl/parcel_store.sv */
`default_nettype none

module parcel_store #(
  parameter int buffer_rows = 8
) (
  input  logic                                            clock,
  input  logic                                            wen,
  input  logic [$clog2(buffer_rows)-1:0]                  waddr,
  input  fetch_pkg::pc_t                                  pc,
  input  fetch_pkg::fetch_word_t                          rdata,
  input  logic [3:0][$clog2(buffer_rows)-1:0]             raddr,
  output fetch_pkg::parcel_row_t                          bank_rdata,
  output fetch_pkg::parcel_row_t                          write_row
);
  import fetch_pkg::*;

  pc_t                 tag_pc [4];
  parcel_entry_t [3:0] wr_entries;
  parcel_entry_t [3:0] rd_entries;

  assign tag_pc[0] = pc;

  for (genvar k = 0; k < 4; k++) begin : g_bank
    parcel_entry_t mem [buffer_rows];  // bank k holds parcel k of every fetched word

    if (k > 0) begin : g_tag
      assign tag_pc[k] = tag_pc[k-1] + 32'd2;
    end

    assign wr_entries[k].pc     = tag_pc[k];
    assign wr_entries[k].parcel = rdata[16*k +: 16];

    always_ff @(posedge clock) begin
      if (wen) begin
        mem[waddr] <= wr_entries[k];
      end
    end

    assign rd_entries[k] = mem[raddr[k]];  // asynchronous read
  end

  assign write_row  = parcel_row_t'(wr_entries);
  assign bank_rdata = parcel_row_t'(rd_entries);

endmodule

`default_nettype wire

/* rtl/parcel_rotator.sv */
`default_nettype none

module parcel_rotator #(
  parameter int buffer_rows = 8
) (
  input  logic                                wen,
  input  logic [$clog2(buffer_rows)-1:0]      wrow,
  input  logic [$clog2(buffer_rows)+1:0]      rptr,
  input  fetch_pkg::parcel_row_t              bank_rdata,
  input  fetch_pkg::parcel_row_t              write_row,
  output logic [3:0][$clog2(buffer_rows)-1:0] raddr,
  output fetch_pkg::parcel_row_t              window
);
  import fetch_pkg::*;

  localparam int row_bits = $clog2(buffer_rows);

  logic [row_bits-1:0] base_row;
  logic [row_bits-1:0] next_row;
  logic [1:0]          offset;
  parcel_entry_t [3:0] banks;
  parcel_entry_t [3:0] fresh;
  parcel_entry_t [3:0] selected;
  parcel_entry_t [3:0] ordered;

  assign base_row = rptr[row_bits+1:2];
  assign offset   = rptr[1:0];
  assign next_row = base_row + row_bits'(1);

  assign banks = bank_rdata;
  assign fresh = write_row;

  // banks below the offset already wrapped into the following row
  always_comb begin
    for (int k = 0; k < 4; k++) begin
      raddr[k] = (k < offset) ? next_row : base_row;
    end
  end

  // the row being written now is not in the banks yet, so take it from the input
  always_comb begin
    for (int k = 0; k < 4; k++) begin
      if (wen && raddr[k] == wrow) begin
        selected[k] = fresh[k];
      end else begin
        selected[k] = banks[k];
      end
    end
  end

  always_comb begin
    logic [1:0] idx;
    idx = 2'd0;
    for (int i = 0; i < 4; i++) begin
      idx        = offset + 2'(i);
      ordered[i] = selected[idx];  // window parcel i is bank offset+i
    end
  end

  assign window = parcel_row_t'(ordered);

endmodule

`default_nettype wire

/* rtl/instr_splitter.sv */
`default_nettype none

module instr_splitter #(
  parameter int buffer_rows = 8
) (
  input  fetch_pkg::parcel_row_t           window,
  input  logic [$clog2(buffer_rows)+2:0]   avail,
  input  logic                             stall,
  output fetch_pkg::issue_out_t            slots,
  output logic [2:0]                       consumed
);
  import fetch_pkg::*;

  parcel_entry_t [3:0] par;
  logic [3:0]          comp;    // parcel opens a compressed instruction
  logic                ready0;
  logic                ready1;
  logic [2:0]          used0;
  logic [2:0]          used1;
  logic [1:0]          start1;
  pc_t                 pc0;
  pc_t                 pc1;
  instr_t              instr0;
  instr_t              instr1;

  assign par = window;

  always_comb begin
    for (int k = 0; k < 4; k++) begin
      comp[k] = (par[k].parcel[1:0] != 2'b11);
    end
  end

  always_comb begin
    ready0 = 1'b0;
    used0  = 3'd0;
    pc0    = par[0].pc;
    instr0 = {16'b0, par[0].parcel};
    if (comp[0]) begin
      if (avail != 0) begin
        ready0 = 1'b1;
        used0  = 3'd1;
      end
    end else if (avail > 3'd1) begin
      ready0 = 1'b1;
      used0  = 3'd2;
      instr0 = {par[1].parcel, par[0].parcel};
    end

    // slot 1 starts right after slot 0 and only issues behind it
    start1 = used0[1:0];
    ready1 = 1'b0;
    used1  = 3'd0;
    pc1    = par[start1].pc;
    instr1 = {16'b0, par[start1].parcel};
    if (ready0) begin
      if (comp[start1]) begin
        if (avail > used0) begin
          ready1 = 1'b1;
          used1  = 3'd1;
        end
      end else if (avail > used0 + 3'd1) begin
        ready1 = 1'b1;
        used1  = 3'd2;
        instr1 = {par[start1 + 2'd1].parcel, par[start1].parcel};
      end
    end

    if (stall) begin
      ready0 = 1'b0;
      ready1 = 1'b0;
      used0  = 3'd0;
      used1  = 3'd0;
    end
  end

  always_comb begin
    slots.pc0    = ready0 ? pc0 : '1;
    slots.pc1    = ready1 ? pc1 : '1;
    slots.instr0 = ready0 ? instr0 : '0;
    slots.instr1 = ready1 ? instr1 : '0;
    slots.ready0 = ready0;
    slots.ready1 = ready1;
    slots.full   = 1'b0;  // the top level fills this in from the control
  end

  assign consumed = used0 + used1;

endmodule

`default_nettype wire

/* rtl/fetch_buffer_ctrl.sv */
`default_nettype none

module fetch_buffer_ctrl #(
  parameter int buffer_rows = 8
) (
  input  logic                             clock,
  input  logic                             reset,
  input  fetch_pkg::fetch_in_t             fetch_in,
  input  logic [2:0]                       consumed,
  output logic                             wen,
  output logic [$clog2(buffer_rows)-1:0]   wrow,
  output logic [$clog2(buffer_rows)+1:0]   rptr,
  output logic [$clog2(buffer_rows)+2:0]   avail,
  output logic                             full
);
  localparam int row_bits = $clog2(buffer_rows);

  typedef logic [row_bits-1:0] row_ptr_t;
  typedef logic [row_bits+1:0] parcel_ptr_t;
  // the count runs from 0 to 4*buffer_rows and needs one bit more than the parcel pointer
  typedef logic [row_bits+2:0] count_t;

  localparam count_t full_level = count_t'(4 * buffer_rows - 4);

  row_ptr_t    wrow_q;
  parcel_ptr_t rptr_q;
  count_t      count_q;
  logic        skip_q;
  logic        full_q;

  row_ptr_t    wrow_base;
  parcel_ptr_t rptr_base;
  count_t      count_base;
  logic        skip_base;
  count_t      count_next;

  // a clear takes effect in the cycle it is seen
  always_comb begin
    if (fetch_in.clear) begin
      wrow_base  = '0;
      rptr_base  = parcel_ptr_t'(fetch_in.align);
      count_base = '0;
      skip_base  = fetch_in.align;
    end else begin
      wrow_base  = wrow_q;
      rptr_base  = rptr_q;
      count_base = count_q;
      skip_base  = skip_q;
    end
  end

  assign wen  = fetch_in.ready & ~fetch_in.clear & ~full_q;
  assign wrow = wrow_base;
  assign rptr = rptr_base;

  // the skipped parcel only exists once the word after the clear arrives
  assign avail = wen ? count_base + count_t'(4) - count_t'(skip_base) : count_base;

  assign count_next = avail - count_t'(consumed);
  assign full       = (count_next > full_level);

  always_ff @(posedge clock) begin
    if (!reset) begin
      wrow_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
      skip_q  <= 1'b0;
      full_q  <= 1'b0;
    end else begin
      wrow_q  <= wrow_base + row_ptr_t'(wen);
      rptr_q  <= rptr_base + parcel_ptr_t'(consumed);
      count_q <= count_next;
      skip_q  <= skip_base & ~wen;
      full_q  <= full;  // next cycle's write enable sees this
    end
  end

endmodule

`default_nettype wire

/* rtl/fetch_buffer.sv */
`default_nettype none

module fetch_buffer #(
  parameter int buffer_rows = 8
) (
  input  logic                  clock,
  input  logic                  reset,
  input  fetch_pkg::fetch_in_t  fetch_in,
  output fetch_pkg::issue_out_t issue_out
);
  import fetch_pkg::*;

  localparam int row_bits = $clog2(buffer_rows);

  logic                     wen;
  logic [row_bits-1:0]      wrow;
  logic [row_bits+1:0]      rptr;
  logic [row_bits+2:0]      avail;
  logic                     full;
  logic [2:0]               consumed;
  logic [3:0][row_bits-1:0] raddr;
  parcel_row_t              bank_rdata;
  parcel_row_t              write_row;
  parcel_row_t              window;
  issue_out_t               slots;

  fetch_buffer_ctrl #(.buffer_rows(buffer_rows)) i_ctrl (
    .clock    (clock),
    .reset    (reset),
    .fetch_in (fetch_in),
    .consumed (consumed),
    .wen      (wen),
    .wrow     (wrow),
    .rptr     (rptr),
    .avail    (avail),
    .full     (full)
  );

  parcel_store #(.buffer_rows(buffer_rows)) i_store (
    .clock      (clock),
    .wen        (wen),
    .waddr      (wrow),
    .pc         (fetch_in.pc),
    .rdata      (fetch_in.rdata),
    .raddr      (raddr),
    .bank_rdata (bank_rdata),
    .write_row  (write_row)
  );

  parcel_rotator #(.buffer_rows(buffer_rows)) i_rotator (
    .wen        (wen),
    .wrow       (wrow),
    .rptr       (rptr),
    .bank_rdata (bank_rdata),
    .write_row  (write_row),
    .raddr      (raddr),
    .window     (window)
  );

  instr_splitter #(.buffer_rows(buffer_rows)) i_splitter (
    .window   (window),
    .avail    (avail),
    .stall    (fetch_in.stall),
    .slots    (slots),
    .consumed (consumed)
  );

  always_comb begin
    issue_out      = slots;
    issue_out.full = full;
  end

endmodule

`default_nettype wire

/* tests/fetch_buffer_tb.sv */
`default_nettype none

module fetch_buffer_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import fetch_pkg::*;

  localparam int buffer_rows    = 8;
  localparam int timeout_cycles = 2000;

  logic          clock;
  logic          reset;
  fetch_in_t     fetch_in;
  issue_out_t    issue_out;
  int            errors;
  int            checks;
  string         test_name;
  parcel_entry_t model_q [$];  // accepted parcels waiting to issue in program order
  logic          model_skip;
  logic          model_full;
  logic          accepted;
  logic          need_word;
  logic          skip_first;
  logic          upper_due;    // next parcel is the top half of a 32-bit instruction
  int            mode;         // 0 all 32-bit, 1 all compressed, 2 mixed
  pc_t           next_pc;
  pc_t           word_pc;
  fetch_word_t   word;

  fetch_buffer #(.buffer_rows(buffer_rows)) i_dut (
    .clock     (clock),
    .reset     (reset),
    .fetch_in  (fetch_in),
    .issue_out (issue_out)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("MISMATCH %s.%s expected %h actual %h", test_name, name, expected, actual);
    end
  endtask

  function automatic parcel_t next_parcel();
    parcel_t p;
    p = parcel_t'($urandom);
    if (upper_due) begin
      upper_due = 1'b0;
    end else if (mode == 0 || (mode == 2 && $urandom_range(1) == 1)) begin
      p[1:0]    = 2'b11;
      upper_due = 1'b1;
    end else if (p[1:0] == 2'b11) begin
      p[1:0] = 2'b01;
    end
    return p;
  endfunction

  // issue rules applied to the head of the model queue
  function automatic issue_out_t expect_slots(input logic stalled, output int used);
    issue_out_t res;
    pc_t        spc [2];
    instr_t     sins [2];
    logic       srdy [2];
    int         pos;
    pos = 0;
    for (int s = 0; s < 2; s++) begin
      srdy[s] = 1'b0;
      spc[s]  = '1;
      sins[s] = '0;
      if (!stalled && (s == 0 || srdy[0]) && pos < model_q.size()) begin
        if (model_q[pos].parcel[1:0] != 2'b11) begin
          srdy[s] = 1'b1;
          spc[s]  = model_q[pos].pc;
          sins[s] = {16'h0, model_q[pos].parcel};
          pos     = pos + 1;
        end else if (pos + 1 < model_q.size()) begin
          srdy[s] = 1'b1;
          spc[s]  = model_q[pos].pc;
          sins[s] = {model_q[pos+1].parcel, model_q[pos].parcel};
          pos     = pos + 2;
        end
      end
    end
    res = '{pc0: spc[0], pc1: spc[1], instr0: sins[0], instr1: sins[1],
            ready0: srdy[0], ready1: srdy[1], full: 1'b0};
    res.full = (model_q.size() - pos) > 4 * buffer_rows - 4;
    used     = pos;
    return res;
  endfunction

  always @(negedge clock) begin : model_check
    issue_out_t    exp_out;
    parcel_entry_t ent;
    int            used;
    logic          wen;
    if (!reset) begin
      model_q.delete();
      model_skip = 1'b0;
      model_full = 1'b0;
      accepted   = 1'b0;
    end else begin
      if (fetch_in.clear) begin
        model_q.delete();
        model_skip = fetch_in.align;
      end
      wen = fetch_in.ready && !fetch_in.clear && !model_full;
      if (wen) begin
        for (int k = 0; k < 4; k++) begin
          ent.pc     = fetch_in.pc + pc_t'(2 * k);
          ent.parcel = fetch_in.rdata[16*k +: 16];
          if (k > 0 || !model_skip) begin
            model_q.push_back(ent);
          end
        end
        model_skip = 1'b0;
      end
      exp_out = expect_slots(fetch_in.stall, used);
      check_value("ready0", exp_out.ready0, issue_out.ready0);
      check_value("ready1", exp_out.ready1, issue_out.ready1);
      check_value("pc0", exp_out.pc0, issue_out.pc0);
      check_value("pc1", exp_out.pc1, issue_out.pc1);
      check_value("instr0", exp_out.instr0, issue_out.instr0);
      check_value("instr1", exp_out.instr1, issue_out.instr1);
      check_value("full", exp_out.full, issue_out.full);
      for (int i = 0; i < used; i++) begin
        void'(model_q.pop_front());
      end
      model_full = exp_out.full;
      accepted   = wen;
    end
  end

  // a fetched word is held until the buffer takes it
  task automatic drive_cycle(input logic rdy, input logic stl, input logic clr, input logic aln);
    @(posedge clock);
    #2;
    if (clr) begin
      need_word  = 1'b1;
      skip_first = aln;
      upper_due  = 1'b0;
      next_pc    = $urandom & 32'hffff_fff8;  // new jump target
    end else if (accepted || need_word) begin
      for (int k = 0; k < 4; k++) begin
        if (k == 0 && skip_first) begin
          word[15:0] = parcel_t'($urandom);  // never issued
        end else begin
          word[16*k +: 16] = next_parcel();
        end
      end
      word_pc    = next_pc;
      next_pc    = next_pc + 32'd8;
      need_word  = 1'b0;
      skip_first = 1'b0;
    end
    fetch_in = '{ready: rdy, clear: clr, align: aln, stall: stl, pc: word_pc, rdata: word};
  endtask

  task automatic drain();
    int cycles;
    cycles = 0;
    do begin
      drive_cycle(1'b0, 1'b0, 1'b0, 1'b0);
      @(negedge clock);
      cycles++;
    end while ((issue_out.ready0 || issue_out.ready1) && cycles < timeout_cycles);
    if (issue_out.ready0 || issue_out.ready1) begin
      errors++;
      $display("timeout: buffer still issuing after %0d idle cycles", timeout_cycles);
    end
  endtask

  initial begin
    int cycles;
    void'($urandom(91306));
    errors     = 0;
    checks     = 0;
    test_name  = "reset";
    reset      = 1'b0;
    fetch_in   = '0;
    need_word  = 1'b1;
    skip_first = 1'b0;
    upper_due  = 1'b0;
    mode       = 0;
    next_pc    = 32'h0000_1000;
    word_pc    = '0;
    word       = '0;
    repeat (3) @(posedge clock);
    #2;
    reset = 1'b1;
    @(negedge clock);
    check_value("ready0", 1'b0, issue_out.ready0);
    check_value("ready1", 1'b0, issue_out.ready1);
    check_value("full", 1'b0, issue_out.full);
    check_value("pc0", '1, issue_out.pc0);
    check_value("pc1", '1, issue_out.pc1);

    test_name = "stream32";
    repeat (60) drive_cycle(1'b1, 1'b0, 1'b0, 1'b0);
    test_name = "stream16";
    mode      = 1;
    repeat (60) drive_cycle(1'b1, 1'b0, 1'b0, 1'b0);
    test_name = "mixed";
    mode      = 2;
    repeat (120) drive_cycle(1'b1, 1'b0, 1'b0, 1'b0);

    test_name = "bypass";
    drive_cycle(1'b0, 1'b0, 1'b1, 1'b0);
    drive_cycle(1'b1, 1'b0, 1'b0, 1'b0);
    @(negedge clock);
    check_value("ready0", 1'b1, issue_out.ready0);
    check_value("pc0", word_pc, issue_out.pc0);

    test_name = "stall";
    cycles    = 0;
    do begin
      drive_cycle(1'b1, 1'b1, 1'b0, 1'b0);
      @(negedge clock);
      check_value("ready0", 1'b0, issue_out.ready0);
      check_value("ready1", 1'b0, issue_out.ready1);
      cycles++;
    end while (!issue_out.full && cycles < timeout_cycles);
    if (!issue_out.full) begin
      errors++;
      $display("timeout: full never rose while issue was stalled");
    end
    drain();

    test_name = "clear";
    repeat (3) drive_cycle(1'b1, 1'b1, 1'b0, 1'b0);
    drive_cycle(1'b0, 1'b0, 1'b1, 1'b0);
    @(negedge clock);
    check_value("ready0", 1'b0, issue_out.ready0);
    repeat (10) drive_cycle(1'b1, 1'b0, 1'b0, 1'b0);
    test_name = "align";
    repeat (3) drive_cycle(1'b1, 1'b1, 1'b0, 1'b0);
    drive_cycle(1'b0, 1'b0, 1'b1, 1'b1);
    @(negedge clock);
    check_value("ready0", 1'b0, issue_out.ready0);
    drive_cycle(1'b1, 1'b0, 1'b0, 1'b0);
    @(negedge clock);
    check_value("ready0", 1'b1, issue_out.ready0);
    check_value("pc0", word_pc + 32'd2, issue_out.pc0);
    repeat (10) drive_cycle(1'b1, 1'b0, 1'b0, 1'b0);

    test_name = "random";
    for (int i = 0; i < 1500; i++) begin
      drive_cycle($urandom_range(3) != 0, $urandom_range(3) == 0,
                  $urandom_range(99) == 0, 1'($urandom_range(1)));
    end
    drain();

    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
rtl/fetch_pkg.sv
rtl/parcel_store.sv
rtl/parcel_rotator.sv
rtl/instr_splitter.sv
rtl/fetch_buffer_ctrl.sv
rtl/fetch_buffer.sv
tests/fetch_buffer_tb.sv

/* Bender.yml */
package:
  name: fetch_buffer

sources:
  - files:
      - rtl/fetch_pkg.sv
      - rtl/parcel_store.sv
      - rtl/parcel_rotator.sv
      - rtl/instr_splitter.sv
      - rtl/fetch_buffer_ctrl.sv
      - rtl/fetch_buffer.sv
  - target: test
    files:
      - tests/fetch_buffer_tb.sv
